//--- vmul_pkg.sv
package vmul_pkg;

	localparam int VEC_WIDTH       = 64;
	// 16-bit half plus one sign bit
	localparam int OPND_WIDTH      = 17;
	localparam int PROD_WIDTH      = 34;
	localparam int WORD_PROD_WIDTH = 66;
	localparam int NUM_UNITS       = 4;

	// tag addr is full width, ports are sized by ADDR_WIDTH
	localparam int TAG_ADDR_WIDTH  = 32;

	// element width, SEW_64 is not supported and gives zero
	typedef enum logic [1:0] {
		SEW_8  = 2'd0,
		SEW_16 = 2'd1,
		SEW_32 = 2'd2,
		SEW_64 = 2'd3
	} sew_e;

	typedef enum logic [1:0] {
		OP_MUL    = 2'd0,
		OP_MULH   = 2'd1,
		OP_MULHU  = 2'd2,
		OP_MULHSU = 2'd3
	} op_e;

	// operand halves for one unit
	// a1/b1 are the upper halves in 32-bit mode
	typedef struct packed {
		logic signed [OPND_WIDTH-1:0] a0;
		logic signed [OPND_WIDTH-1:0] a1;
		logic signed [OPND_WIDTH-1:0] b0;
		logic signed [OPND_WIDTH-1:0] b1;
	} unit_opnd_t;

	typedef struct packed {
		logic signed [PROD_WIDTH-1:0]      p0;
		logic signed [PROD_WIDTH-1:0]      p1;
		logic signed [WORD_PROD_WIDTH-1:0] word;
	} unit_prod_t;

	// sideband carried alongside each item
	typedef struct packed {
		sew_e                      sew;
		op_e                       op;
		logic [TAG_ADDR_WIDTH-1:0] addr;
	} tag_t;

endpackage

//--- vmul_operand_select.sv
`timescale 1ns/1ps

module vmul_operand_select #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                                                  clk,
	input  logic                                                  rst,
	input  logic [vmul_pkg::VEC_WIDTH-1:0]                        vec0,
	input  logic [vmul_pkg::VEC_WIDTH-1:0]                        vec1,
	input  logic                                                  valid,
	input  vmul_pkg::sew_e                                        sew,
	input  vmul_pkg::op_e                                         op,
	input  logic [ADDR_WIDTH-1:0]                                 addr,
	output vmul_pkg::unit_opnd_t [vmul_pkg::NUM_UNITS-1:0]        opnd,
	output vmul_pkg::tag_t                                        tag,
	output logic                                                  opnd_valid
);

	vmul_pkg::unit_opnd_t [vmul_pkg::NUM_UNITS-1:0] opnd_next;
	vmul_pkg::tag_t                                 tag_next;
	logic                                           sx_a;
	logic                                           sx_b;
	logic [4*vmul_pkg::NUM_UNITS-1:0]               opnd_msb;

	function automatic logic [vmul_pkg::OPND_WIDTH-1:0] ext8(input logic [7:0] v, input logic sx);
		return {{(vmul_pkg::OPND_WIDTH - 8){sx & v[7]}}, v};
	endfunction

	function automatic logic [vmul_pkg::OPND_WIDTH-1:0] ext16(input logic [15:0] v, input logic sx);
		return {sx & v[15], v};
	endfunction

	// a is signed for mulh and mulhsu, b only for mulh
	assign sx_a = (op == vmul_pkg::OP_MULH) || (op == vmul_pkg::OP_MULHSU);
	assign sx_b = (op == vmul_pkg::OP_MULH);

	always_comb begin
		opnd_next = '0;
		case (sew)
			vmul_pkg::SEW_8: begin
				// byte pairs fill units 3 down to 0, even byte on the upper half
				for (int k = 0; k < 8; k++) begin
					if (k % 2 == 0) begin
						opnd_next[3 - k / 2].a1 = ext8(vec0[8*k +: 8], sx_a);
						opnd_next[3 - k / 2].b1 = ext8(vec1[8*k +: 8], sx_b);
					end else begin
						opnd_next[3 - k / 2].a0 = ext8(vec0[8*k +: 8], sx_a);
						opnd_next[3 - k / 2].b0 = ext8(vec1[8*k +: 8], sx_b);
					end
				end
			end
			vmul_pkg::SEW_16: begin
				// only units 3 and 0 in use
				for (int k = 0; k < 4; k++) begin
					if (k % 2 == 0) begin
						opnd_next[(k < 2) ? 3 : 0].a1 = ext16(vec0[16*k +: 16], sx_a);
						opnd_next[(k < 2) ? 3 : 0].b1 = ext16(vec1[16*k +: 16], sx_b);
					end else begin
						opnd_next[(k < 2) ? 3 : 0].a0 = ext16(vec0[16*k +: 16], sx_a);
						opnd_next[(k < 2) ? 3 : 0].b0 = ext16(vec1[16*k +: 16], sx_b);
					end
				end
			end
			vmul_pkg::SEW_32: begin
				for (int k = 0; k < 2; k++) begin
					opnd_next[(k == 0) ? 3 : 0].a1 = ext16(vec0[32*k+16 +: 16], sx_a);
					opnd_next[(k == 0) ? 3 : 0].b1 = ext16(vec1[32*k+16 +: 16], sx_b);
					// lower halves are magnitude bits only
					opnd_next[(k == 0) ? 3 : 0].a0 = ext16(vec0[32*k +: 16], 1'b0);
					opnd_next[(k == 0) ? 3 : 0].b0 = ext16(vec1[32*k +: 16], 1'b0);
				end
			end
			default: begin
				opnd_next = '0;
			end
		endcase
	end

	always_comb begin
		tag_next = '0;
		tag_next.sew = sew;
		tag_next.op = op;
		tag_next.addr[ADDR_WIDTH-1:0] = addr;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			opnd       <= '0;
			tag        <= '0;
			opnd_valid <= 1'b0;
		end else begin
			opnd_valid <= valid;
			if (valid) begin
				opnd <= opnd_next;
				tag  <= tag_next;
			end else begin
				opnd <= '0;
				tag  <= '0;
			end
		end
	end

	// extension bit of every registered operand half
	always_comb begin
		for (int i = 0; i < vmul_pkg::NUM_UNITS; i++) begin
			opnd_msb[4*i]     = opnd[i].a0[vmul_pkg::OPND_WIDTH-1];
			opnd_msb[4*i + 1] = opnd[i].a1[vmul_pkg::OPND_WIDTH-1];
			opnd_msb[4*i + 2] = opnd[i].b0[vmul_pkg::OPND_WIDTH-1];
			opnd_msb[4*i + 3] = opnd[i].b1[vmul_pkg::OPND_WIDTH-1];
		end
	end

	// mul and mulhu see zero filled operands only
	a_unsigned_zero_fill: assert property (@(posedge clk) disable iff (rst)
		(opnd_valid && (tag.op == vmul_pkg::OP_MUL || tag.op == vmul_pkg::OP_MULHU))
		|-> opnd_msb == '0);

endmodule

//--- vmul_mult32.sv
`timescale 1ns/1ps

module vmul_mult32 (
	input  logic                 clk,
	input  logic                 rst,
	input  vmul_pkg::unit_opnd_t opnd,
	output vmul_pkg::unit_prod_t prod
);

	logic signed [vmul_pkg::PROD_WIDTH-1:0]      p00;
	logic signed [vmul_pkg::PROD_WIDTH-1:0]      p01;
	logic signed [vmul_pkg::PROD_WIDTH-1:0]      p10;
	logic signed [vmul_pkg::PROD_WIDTH-1:0]      p11;
	logic signed [vmul_pkg::WORD_PROD_WIDTH-1:0] w00;
	logic signed [vmul_pkg::WORD_PROD_WIDTH-1:0] w_cross;
	logic signed [vmul_pkg::WORD_PROD_WIDTH-1:0] w11;

	// four 17x17 signed products
	always_ff @(posedge clk) begin
		if (rst) begin
			p00 <= '0;
			p01 <= '0;
			p10 <= '0;
			p11 <= '0;
		end else begin
			p00 <= $signed(opnd.a0) * $signed(opnd.b0);
			p01 <= $signed(opnd.a0) * $signed(opnd.b1);
			p10 <= $signed(opnd.a1) * $signed(opnd.b0);
			p11 <= $signed(opnd.a1) * $signed(opnd.b1);
		end
	end

	// sign extend before the shifts
	assign w00     = p00;
	assign w11     = p11;
	assign w_cross = vmul_pkg::WORD_PROD_WIDTH'(p01) + vmul_pkg::WORD_PROD_WIDTH'(p10);

	always_ff @(posedge clk) begin
		if (rst) begin
			prod <= '0;
		end else begin
			prod.p0   <= p00;
			prod.p1   <= p11;
			prod.word <= (w11 <<< 32) + (w_cross <<< 16) + w00;
		end
	end

	a_prod_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(prod));

endmodule

//--- vmul_result_select.sv
`timescale 1ns/1ps

module vmul_result_select #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                                           clk,
	input  logic                                           rst,
	input  vmul_pkg::unit_prod_t [vmul_pkg::NUM_UNITS-1:0] prod,
	input  vmul_pkg::tag_t                                 tag,
	input  logic                                           opnd_valid,
	output logic [vmul_pkg::VEC_WIDTH-1:0]                 vec,
	output logic                                           valid,
	output logic [ADDR_WIDTH-1:0]                          addr
);

	vmul_pkg::tag_t                 tag_d1;
	vmul_pkg::tag_t                 tag_d2;
	logic                           valid_d1;
	logic                           valid_d2;
	logic                           hi;
	logic [vmul_pkg::VEC_WIDTH-1:0] vec_next;

	function automatic logic [7:0] pick8(
		input logic [vmul_pkg::PROD_WIDTH-1:0] p,
		input logic                            sel_hi
	);
		return sel_hi ? p[15:8] : p[7:0];
	endfunction

	function automatic logic [15:0] pick16(
		input logic [vmul_pkg::PROD_WIDTH-1:0] p,
		input logic                            sel_hi
	);
		return sel_hi ? p[31:16] : p[15:0];
	endfunction

	function automatic logic [31:0] pick32(
		input logic [vmul_pkg::WORD_PROD_WIDTH-1:0] w,
		input logic                                 sel_hi
	);
		return sel_hi ? w[63:32] : w[31:0];
	endfunction

	// tag and valid wait out the two multiplier stages
	always_ff @(posedge clk) begin
		if (rst) begin
			tag_d1   <= '0;
			tag_d2   <= '0;
			valid_d1 <= 1'b0;
			valid_d2 <= 1'b0;
		end else begin
			tag_d1   <= tag;
			tag_d2   <= tag_d1;
			valid_d1 <= opnd_valid;
			valid_d2 <= valid_d1;
		end
	end

	assign hi = (tag_d2.op != vmul_pkg::OP_MUL);

	always_comb begin
		vec_next = '0;
		case (tag_d2.sew)
			vmul_pkg::SEW_8: begin
				for (int k = 0; k < 8; k++) begin
					vec_next[8*k +: 8] = pick8((k % 2 == 0) ? prod[3 - k / 2].p1 :
						prod[3 - k / 2].p0, hi);
				end
			end
			vmul_pkg::SEW_16: begin
				for (int k = 0; k < 4; k++) begin
					vec_next[16*k +: 16] = pick16((k % 2 == 0) ? prod[(k < 2) ? 3 : 0].p1 :
						prod[(k < 2) ? 3 : 0].p0, hi);
				end
			end
			vmul_pkg::SEW_32: begin
				vec_next[31:0]  = pick32(prod[3].word, hi);
				vec_next[63:32] = pick32(prod[0].word, hi);
			end
			default: begin
				vec_next = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vec   <= '0;
			valid <= 1'b0;
			addr  <= '0;
		end else begin
			valid <= valid_d2;
			vec   <= valid_d2 ? vec_next : '0;
			// upper tag bits are dropped here
			addr  <= tag_d2.addr[ADDR_WIDTH-1:0];
		end
	end

	// only byte mode uses units 1 and 2
	a_mid_units_idle: assert property (@(posedge clk) disable iff (rst)
		(valid_d2 && tag_d2.sew != vmul_pkg::SEW_8) |-> (prod[1] == '0 && prod[2] == '0));

endmodule

//--- vmul_top.sv
`timescale 1ns/1ps

module vmul_top #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [vmul_pkg::VEC_WIDTH-1:0] in_vec0,
	input  logic [vmul_pkg::VEC_WIDTH-1:0] in_vec1,
	input  logic                           in_valid,
	input  vmul_pkg::sew_e                 in_sew,
	input  vmul_pkg::op_e                  in_op,
	input  logic [ADDR_WIDTH-1:0]          in_addr,
	output logic [vmul_pkg::VEC_WIDTH-1:0] out_vec,
	output logic                           out_valid,
	output logic [ADDR_WIDTH-1:0]          out_addr
);

	vmul_pkg::unit_opnd_t [vmul_pkg::NUM_UNITS-1:0] opnd;
	vmul_pkg::unit_prod_t [vmul_pkg::NUM_UNITS-1:0] prod;
	vmul_pkg::tag_t                                 tag;
	logic                                           opnd_valid;

	vmul_operand_select #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_operand_select (
		.clk        (clk),
		.rst        (rst),
		.vec0       (in_vec0),
		.vec1       (in_vec1),
		.valid      (in_valid),
		.sew        (in_sew),
		.op         (in_op),
		.addr       (in_addr),
		.opnd       (opnd),
		.tag        (tag),
		.opnd_valid (opnd_valid)
	);

	for (genvar i = 0; i < vmul_pkg::NUM_UNITS; i++) begin : u_mult
		vmul_mult32 u_unit (
			.clk  (clk),
			.rst  (rst),
			.opnd (opnd[i]),
			.prod (prod[i])
		);
	end

	vmul_result_select #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_result_select (
		.clk        (clk),
		.rst        (rst),
		.prod       (prod),
		.tag        (tag),
		.opnd_valid (opnd_valid),
		.vec        (out_vec),
		.valid      (out_valid),
		.addr       (out_addr)
	);

endmodule

//--- tb_vmul_ref.svh
`ifndef TB_VMUL_REF_SVH
`define TB_VMUL_REF_SVH

logic [31:0] lcg_state;

// 32-bit LCG, full state returned
function automatic logic [31:0] rand32();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

function automatic logic [63:0] rand64();
	logic [63:0] v;
	v[63:32] = rand32();
	v[31:0]  = rand32();
	return v;
endfunction

// keep w low bits, then sign or zero fill the rest
function automatic logic [63:0] lane_ext(input logic [63:0] v, input int w, input logic sx);
	logic [63:0] mask;
	logic [63:0] r;
	mask = (64'd1 << w) - 64'd1;
	r = v & mask;
	if (sx && r[w-1]) begin
		r = r | ~mask;
	end
	return r;
endfunction

// expected vector for one item
function automatic logic [63:0] ref_vmul(
	input logic [63:0]    a,
	input logic [63:0]    b,
	input vmul_pkg::sew_e sew,
	input vmul_pkg::op_e  op
);
	int          w;
	logic [63:0] mask;
	logic [63:0] ea;
	logic [63:0] eb;
	logic [63:0] full;
	logic [63:0] lane;
	logic [63:0] res;
	logic        sa;
	logic        sb;
	res = '0;
	if (sew == vmul_pkg::SEW_64) begin
		return res;
	end
	w = 8 << int'(sew);
	mask = (64'd1 << w) - 64'd1;
	sa = (op == vmul_pkg::OP_MULH) || (op == vmul_pkg::OP_MULHSU);
	sb = (op == vmul_pkg::OP_MULH);
	for (int i = 0; i < 64 / w; i++) begin
		ea = lane_ext(a >> (w * i), w, sa);
		eb = lane_ext(b >> (w * i), w, sb);
		// the 2w-bit product always fits in 64 bits
		full = ea * eb;
		lane = (op == vmul_pkg::OP_MUL) ? (full & mask) : ((full >> w) & mask);
		res = res | (lane << (w * i));
	end
	return res;
endfunction

`endif

//--- tb_vmul.sv
`timescale 1ns/1ps

module tb_vmul;

	localparam int CLK_HALF       = 20;
	localparam int LATENCY        = 4;
	localparam int RAND_PER_OP    = 6;
	localparam int LAT_ITEMS      = 12;
	localparam int NUM_ITEMS      = 4 * (RAND_PER_OP + 1) + 8 * (RAND_PER_OP + 2) + LAT_ITEMS + 4;
	localparam int TIMEOUT_CYCLES = (NUM_ITEMS + 20) * 2;

	localparam logic [7:0] T_SEW8  = 8'd1;
	localparam logic [7:0] T_SEW16 = 8'd2;
	localparam logic [7:0] T_SEW32 = 8'd3;
	localparam logic [7:0] T_TAG   = 8'd4;
	localparam logic [7:0] T_SEW64 = 8'd5;

	typedef struct packed {
		logic [63:0] vec;
		logic [31:0] addr;
		logic [7:0]  test_id;
		logic [31:0] due;
	} expect_t;

	logic           clk;
	logic           rst;
	logic [63:0]    in_vec0;
	logic [63:0]    in_vec1;
	logic           in_valid;
	vmul_pkg::sew_e in_sew;
	vmul_pkg::op_e  in_op;
	logic [31:0]    in_addr;
	logic [7:0]     in_test;
	logic [63:0]    out_vec;
	logic           out_valid;
	logic [31:0]    out_addr;

	expect_t        exp_q[$];
	expect_t        head;
	logic           head_valid;
	int unsigned    cyc = 0;
	int             vec_errors = 0;
	int             addr_errors = 0;
	int             flow_errors = 0;

	`include "tb_vmul_ref.svh"

	vmul_top #(
		.ADDR_WIDTH (32)
	) u_vmul_top (
		.clk       (clk),
		.rst       (rst),
		.in_vec0   (in_vec0),
		.in_vec1   (in_vec1),
		.in_valid  (in_valid),
		.in_sew    (in_sew),
		.in_op     (in_op),
		.in_addr   (in_addr),
		.out_vec   (out_vec),
		.out_valid (out_valid),
		.out_addr  (out_addr)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic string test_name(input logic [7:0] id);
		case (id)
			T_SEW8:  return "sew8";
			T_SEW16: return "sew16";
			T_SEW32: return "sew32";
			T_TAG:   return "latency_tag";
			T_SEW64: return "sew64";
			default: return "unknown";
		endcase
	endfunction

	// expected results follow the DUT inputs as they are sampled
	always @(posedge clk) begin
		if (rst) begin
			exp_q.delete();
			head       <= '0;
			head_valid <= 1'b0;
		end else begin
			if (out_valid && exp_q.size() > 0) begin
				void'(exp_q.pop_front());
			end
			if (in_valid) begin
				exp_q.push_back({ref_vmul(in_vec0, in_vec1, in_sew, in_op), in_addr, in_test,
					cyc + LATENCY});
			end
			if (exp_q.size() > 0) begin
				head       <= exp_q[0];
				head_valid <= 1'b1;
			end else begin
				head_valid <= 1'b0;
			end
		end
	end

	a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
		else begin
			flow_errors++;
			$display("out_valid was high in the cycle after a reset cycle");
		end

	a_no_extra: assert property (@(posedge clk) disable iff (rst) out_valid |-> head_valid)
		else begin
			flow_errors++;
			$display("out_valid was high at cycle %0d with no item outstanding", $sampled(cyc));
		end

	a_on_time: assert property (@(posedge clk) disable iff (rst)
		(head_valid && cyc == head.due) |-> out_valid)
		else begin
			flow_errors++;
			$display("%s: result missing %0d cycles after issue",
				test_name($sampled(head.test_id)), LATENCY);
		end

	a_not_early: assert property (@(posedge clk) disable iff (rst)
		(out_valid && head_valid) |-> cyc == head.due)
		else begin
			flow_errors++;
			$display("%s: result came at cycle %0d but was due at cycle %0d",
				test_name($sampled(head.test_id)), $sampled(cyc), $sampled(head.due));
		end

	a_vec: assert property (@(posedge clk) disable iff (rst)
		(out_valid && head_valid) |-> out_vec == head.vec)
		else begin
			vec_errors++;
			$display("[ERROR] %s: out_vec expected %h actual %h",
				test_name($sampled(head.test_id)), $sampled(head.vec), $sampled(out_vec));
		end

	a_addr: assert property (@(posedge clk) disable iff (rst)
		(out_valid && head_valid) |-> out_addr == head.addr)
		else begin
			addr_errors++;
			$display("[ERROR] %s: out_addr expected %h actual %h",
				test_name($sampled(head.test_id)), $sampled(head.addr), $sampled(out_addr));
		end

	task automatic issue(
		input logic [63:0]    a,
		input logic [63:0]    b,
		input vmul_pkg::sew_e sew,
		input vmul_pkg::op_e  op,
		input logic [31:0]    addr,
		input logic [7:0]     id
	);
		in_vec0  <= a;
		in_vec1  <= b;
		in_sew   <= sew;
		in_op    <= op;
		in_addr  <= addr;
		in_test  <= id;
		in_valid <= 1'b1;
		@(posedge clk);
	endtask

	task automatic idle(input int n);
		in_valid <= 1'b0;
		repeat (n) @(posedge clk);
	endtask

	task automatic report_counts();
		$display("errors: vec %0d, addr %0d, flow %0d", vec_errors, addr_errors, flow_errors);
	endtask

	initial begin : watchdog
		while (cyc < TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles with %0d items outstanding", cyc, exp_q.size());
		report_counts();
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin : stimulus
		logic [63:0]          a;
		logic [63:0]          b;
		logic [63:0]          neg;
		logic [31:0]          r;
		logic [1:0]           s2;
		vmul_pkg::sew_e       sew;
		logic [7:0]           id;
		int                   gap;
		lcg_state = 32'hfe3ec105;
		rst      <= 1'b1;
		in_valid <= 1'b0;
		in_vec0  <= '0;
		in_vec1  <= '0;
		in_sew   <= vmul_pkg::SEW_8;
		in_op    <= vmul_pkg::OP_MUL;
		in_addr  <= '0;
		in_test  <= '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		idle(2);

		for (int op = 0; op < 4; op++) begin
			for (int n = 0; n < RAND_PER_OP; n++) begin
				a = rand64();
				b = rand64();
				issue(a, b, vmul_pkg::SEW_8, vmul_pkg::op_e'(op[1:0]), rand32(), T_SEW8);
			end
			// 0x80 against 0xff in both orders
			issue(64'h80ff_80ff_80ff_80ff, 64'hff80_ff80_ff80_ff80, vmul_pkg::SEW_8,
				vmul_pkg::op_e'(op[1:0]), rand32(), T_SEW8);
		end
		idle(2);

		for (int k = 0; k < 2; k++) begin
			sew = (k == 0) ? vmul_pkg::SEW_16 : vmul_pkg::SEW_32;
			id  = (k == 0) ? T_SEW16 : T_SEW32;
			neg = (k == 0) ? 64'h8000_8000_8000_8000 : 64'h8000_0000_8000_0000;
			for (int op = 0; op < 4; op++) begin
				for (int n = 0; n < RAND_PER_OP; n++) begin
					a = rand64();
					b = rand64();
					issue(a, b, sew, vmul_pkg::op_e'(op[1:0]), rand32(), id);
				end
				issue('1, neg, sew, vmul_pkg::op_e'(op[1:0]), rand32(), id);
				issue(neg, '1, sew, vmul_pkg::op_e'(op[1:0]), rand32(), id);
			end
			idle(2);
		end

		// mixed items, some back to back, some with gaps
		for (int n = 0; n < LAT_ITEMS; n++) begin
			r = rand32();
			s2 = 2'(r[23:16] % 8'd3);
			a = rand64();
			b = rand64();
			issue(a, b, vmul_pkg::sew_e'(s2), vmul_pkg::op_e'(r[25:24]), rand32(), T_TAG);
			gap = int'(r[29:28]);
			if (gap != 0) begin
				idle(gap);
			end
		end
		idle(2);

		for (int op = 0; op < 4; op++) begin
			a = rand64();
			b = rand64();
			issue(a, b, vmul_pkg::SEW_64, vmul_pkg::op_e'(op[1:0]), rand32(), T_SEW64);
		end
		in_valid <= 1'b0;

		@(negedge clk);
		while (exp_q.size() != 0) @(negedge clk);
		report_counts();
		if (vec_errors + addr_errors + flow_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+.
vmul_pkg.sv
vmul_operand_select.sv
vmul_mult32.sv
vmul_result_select.sv
vmul_top.sv
tb_vmul.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_vmul -o sim_vmul

out=$(./obj_dir/sim_vmul)
echo "$out"

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
exit 1
